// File: hdl/spu_defines.svh
`ifndef SPU_DEFINES_SVH
`define SPU_DEFINES_SVH

// Architectural register file.
`define SPU_NUM_REGS 128
`define SPU_REG_W $clog2(`SPU_NUM_REGS)

// In-flight stages per execution pipe, stage 0 follows issue.
`define SPU_PIPE_DEPTH 7

// Branches resolve here. Younger stages are cleared on a taken branch.
`define SPU_RESOLVE_STAGE 3

// Wide enough for the longest result latency.
`define SPU_LAT_W 4

`endif

// File: hdl/spu_isa_pkg.sv
`default_nettype none
`include "spu_defines.svh"

package spu_isa_pkg;

  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_logic_op,
    op_shift,
    op_mpy,
    op_fp,
    op_load,
    op_store,
    op_shuffle,
    op_branch
  } opcode_e;

  typedef enum logic {
    pipe_even,
    pipe_odd
  } pipe_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [`SPU_REG_W-1:0]  dst;
    logic [`SPU_REG_W-1:0]  ra;
    logic [`SPU_REG_W-1:0]  rb;
    logic [`SPU_REG_W-1:0]  rc;
    logic                   writes_dst;
    logic                   uses_ra;
    logic                   uses_rb;
    logic                   uses_rc;
  } instr_t;

  typedef struct packed {
    instr_t slot0; // Older of the two.
    instr_t slot1;
  } pair_t;

  function automatic pipe_e op_pipe(opcode_e op);
    case (op)
      op_shift, op_load, op_store, op_shuffle, op_branch: return pipe_odd;
      default:                                           return pipe_even;
    endcase
  endfunction

  function automatic logic [`SPU_LAT_W-1:0] op_latency(opcode_e op);
    case (op)
      op_add, op_shift: return `SPU_LAT_W'd2;
      op_shuffle:       return `SPU_LAT_W'd4;
      op_load:          return `SPU_LAT_W'd6;
      op_mpy, op_fp:    return `SPU_LAT_W'd7;
      default:          return `SPU_LAT_W'd1;
    endcase
  endfunction

  // Nop and store never produce a register result.
  function automatic logic op_writes_dst(opcode_e op);
    return (op != op_nop) && (op != op_store);
  endfunction

endpackage

`default_nettype wire

// File: hdl/spu_pipe_pkg.sv
`default_nettype none
`include "spu_defines.svh"

package spu_pipe_pkg;

  typedef struct packed {
    logic                   valid;
    logic [`SPU_REG_W-1:0]  dst;
    logic [`SPU_LAT_W-1:0]  latency;
  } inflight_t;

  typedef struct packed {
    logic                   valid;
    spu_isa_pkg::opcode_e   opcode;
    logic [`SPU_REG_W-1:0]  dst;
    logic [`SPU_LAT_W-1:0]  latency;
  } issue_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } branch_rpt_t;

  // A decoded instruction waiting for the hazard unit.
  typedef struct packed {
    logic                   valid;
    spu_isa_pkg::instr_t    instr;
    spu_isa_pkg::pipe_e     pipe;
    logic [`SPU_LAT_W-1:0]  latency;
  } cand_t;

  typedef enum logic [1:0] {
    st_idle,
    st_issue_both,
    st_issue_second,
    st_ack_wait
  } issue_state_e;

endpackage

`default_nettype wire

// File: hdl/pair_decoder.sv
`default_nettype none
`include "spu_defines.svh"

module pair_decoder (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 pair_req,
  input  wire spu_isa_pkg::pair_t   pair,
  output logic                      pair_ack,
  output spu_pipe_pkg::cand_t       cand0,
  output spu_pipe_pkg::cand_t       cand1,
  input  wire logic [1:0]           issue_mask,
  input  wire logic                 flush,
  output spu_pipe_pkg::issue_t      issue_even,
  output spu_pipe_pkg::issue_t      issue_odd
);
  import spu_isa_pkg::*;
  import spu_pipe_pkg::*;

  issue_state_e state_q;
  logic         dec_pend_q; // Pair latched, decode happens next cycle.
  pair_t        pair_q;
  cand_t        cand0_q;
  cand_t        cand1_q;

  function automatic cand_t decode(instr_t ins);
    cand_t c;
    c.valid = 1'b1;
    c.instr = ins;
    c.instr.writes_dst = ins.writes_dst & op_writes_dst(ins.opcode);
    c.pipe = op_pipe(ins.opcode);
    c.latency = op_latency(ins.opcode);
    return c;
  endfunction

  function automatic issue_t to_issue(cand_t c);
    issue_t i;
    i.valid = 1'b1;
    i.opcode = c.instr.opcode;
    i.dst = c.instr.dst;
    i.latency = c.latency;
    return i;
  endfunction

  // ######################################
  // Handshake and slot sequencing.
  // ######################################

  always_ff @(posedge clk) begin
    if (state_q == st_idle && !dec_pend_q && pair_req) begin
      pair_q <= pair;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      dec_pend_q <= 1'b0;
      cand0_q.valid <= 1'b0;
      cand1_q.valid <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (dec_pend_q) begin
            dec_pend_q <= 1'b0;
            if (flush) begin
              state_q <= st_ack_wait; // Latched pair is already stale.
            end else begin
              cand0_q <= decode(pair_q.slot0);
              cand1_q <= decode(pair_q.slot1);
              state_q <= st_issue_both;
            end
          end else if (pair_req) begin
            dec_pend_q <= 1'b1;
          end
        end
        st_issue_both: begin
          if (flush || issue_mask == 2'b11) begin
            cand0_q.valid <= 1'b0;
            cand1_q.valid <= 1'b0;
            state_q <= st_ack_wait;
          end else if (issue_mask[0]) begin
            cand0_q <= cand1_q; // Slot1 becomes the head.
            cand1_q.valid <= 1'b0;
            state_q <= st_issue_second;
          end
        end
        st_issue_second: begin
          if (flush || issue_mask[0]) begin
            cand0_q.valid <= 1'b0;
            state_q <= st_ack_wait;
          end
        end
        st_ack_wait: begin
          if (!pair_req) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign pair_ack = (state_q == st_ack_wait);
  assign cand0 = cand0_q;
  assign cand1 = cand1_q;

  // Granted slots never share a pipe, the hazard unit splits them.
  always_comb begin
    issue_even = '0;
    issue_odd = '0;
    if (issue_mask[0]) begin
      if (cand0_q.pipe == pipe_even) issue_even = to_issue(cand0_q);
      else issue_odd = to_issue(cand0_q);
    end
    if (issue_mask[1]) begin
      if (cand1_q.pipe == pipe_even) issue_even = to_issue(cand1_q);
      else issue_odd = to_issue(cand1_q);
    end
  end

endmodule

`default_nettype wire

// File: hdl/inflight_scoreboard.sv
`default_nettype none
`include "spu_defines.svh"

module inflight_scoreboard (
  input  wire logic                                          clk,
  input  wire logic                                          rst,
  input  wire spu_pipe_pkg::issue_t                          issue_even,
  input  wire spu_pipe_pkg::issue_t                          issue_odd,
  input  wire logic                                          flush,
  output spu_pipe_pkg::inflight_t [`SPU_PIPE_DEPTH-1:0]      even_stages,
  output spu_pipe_pkg::inflight_t [`SPU_PIPE_DEPTH-1:0]      odd_stages
);
  import spu_isa_pkg::*;
  import spu_pipe_pkg::*;

  // Index 0 is the even pipe, index 1 the odd pipe.
  inflight_t [`SPU_PIPE_DEPTH-1:0] stages_q [2];
  issue_t                          issue_in [2];

  assign issue_in[0] = issue_even;
  assign issue_in[1] = issue_odd;

  // ######################################
  // Per-pipe shift registers.
  // ######################################

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < 2; p++) begin
        for (int s = 0; s < `SPU_PIPE_DEPTH; s++) begin
          stages_q[p][s].valid <= 1'b0;
        end
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        // Entries with no register result are kept but never match.
        stages_q[p][0].valid <= issue_in[p].valid && !flush &&
                                op_writes_dst(issue_in[p].opcode);
        stages_q[p][0].dst <= issue_in[p].dst;
        stages_q[p][0].latency <= issue_in[p].latency;
        for (int s = 1; s < `SPU_PIPE_DEPTH; s++) begin
          stages_q[p][s] <= stages_q[p][s-1];
          if (flush && (s - 1) < `SPU_RESOLVE_STAGE) begin
            stages_q[p][s].valid <= 1'b0; // Younger than the branch.
          end
        end
      end
    end
  end

  assign even_stages = stages_q[0];
  assign odd_stages = stages_q[1];

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`default_nettype none
`include "spu_defines.svh"

module hazard_unit (
  input  wire logic                                          clk,
  input  wire logic                                          rst,
  input  wire spu_pipe_pkg::cand_t                           cand0,
  input  wire spu_pipe_pkg::cand_t                           cand1,
  input  wire spu_pipe_pkg::inflight_t [`SPU_PIPE_DEPTH-1:0] even_stages,
  input  wire spu_pipe_pkg::inflight_t [`SPU_PIPE_DEPTH-1:0] odd_stages,
  input  wire spu_pipe_pkg::branch_rpt_t                     branch,
  output logic [1:0]                                         issue_mask,
  output logic                                               stall,
  output logic                                               flush
);
  import spu_isa_pkg::*;
  import spu_pipe_pkg::*;

  logic hazard0;
  logic hazard1;
  logic split;

  // Ready once stage index plus one reaches the latency.
  function automatic logic entry_blocks(inflight_t e, int stage, logic [`SPU_REG_W-1:0] src);
    return e.valid && (e.dst == src) && ((stage + 1) < int'(e.latency));
  endfunction

  function automatic logic src_blocked(logic [`SPU_REG_W-1:0] src);
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < `SPU_PIPE_DEPTH; s++) begin
      hit |= entry_blocks(even_stages[s], s, src);
      hit |= entry_blocks(odd_stages[s], s, src);
    end
    return hit;
  endfunction

  function automatic logic cand_hazard(cand_t c);
    return c.valid && ((c.instr.uses_ra && src_blocked(c.instr.ra)) ||
                       (c.instr.uses_rb && src_blocked(c.instr.rb)) ||
                       (c.instr.uses_rc && src_blocked(c.instr.rc)));
  endfunction

  function automatic logic reads_reg(instr_t ins, logic [`SPU_REG_W-1:0] r);
    return (ins.uses_ra && ins.ra == r) ||
           (ins.uses_rb && ins.rb == r) ||
           (ins.uses_rc && ins.rc == r);
  endfunction

  // ######################################
  // Hazard detection.
  // ######################################

  always_comb begin
    hazard0 = cand_hazard(cand0);
    hazard1 = cand_hazard(cand1);
  end

  // Structural, write-after-write and intra-pair read-after-write.
  assign split = cand1.valid &&
                 ((cand0.pipe == cand1.pipe) ||
                  (cand0.instr.writes_dst && cand1.instr.writes_dst &&
                   cand0.instr.dst == cand1.instr.dst) ||
                  (cand0.instr.writes_dst && reads_reg(cand1.instr, cand0.instr.dst)));

  always_ff @(posedge clk) begin
    if (rst) begin
      flush <= 1'b0;
    end else begin
      flush <= branch.valid && branch.taken;
    end
  end

  always_comb begin
    issue_mask = 2'b00;
    stall = 1'b0;
    if (!flush && cand0.valid) begin
      if (hazard0) begin
        stall = 1'b1; // Slot1 waits behind slot0.
      end else if (!cand1.valid || split || hazard1) begin
        issue_mask = 2'b01;
      end else begin
        issue_mask = 2'b11;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/dual_issue_stage.sv
`default_nettype none
`include "spu_defines.svh"

module dual_issue_stage (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       pair_req,
  input  wire spu_isa_pkg::pair_t         pair,
  input  wire spu_pipe_pkg::branch_rpt_t  branch,
  output logic                            pair_ack,
  output spu_pipe_pkg::issue_t            issue_even,
  output spu_pipe_pkg::issue_t            issue_odd,
  output logic                            stall,
  output logic                            flush
);
  import spu_pipe_pkg::*;

  cand_t                           cand0;
  cand_t                           cand1;
  logic [1:0]                      issue_mask;
  inflight_t [`SPU_PIPE_DEPTH-1:0] even_stages;
  inflight_t [`SPU_PIPE_DEPTH-1:0] odd_stages;

  pair_decoder u_decoder (
    .clk(clk), .rst(rst),
    .pair_req(pair_req), .pair(pair), .pair_ack(pair_ack),
    .cand0(cand0), .cand1(cand1),
    .issue_mask(issue_mask), .flush(flush),
    .issue_even(issue_even), .issue_odd(issue_odd)
  );

  hazard_unit u_hazard (
    .clk(clk), .rst(rst),
    .cand0(cand0), .cand1(cand1),
    .even_stages(even_stages), .odd_stages(odd_stages),
    .branch(branch),
    .issue_mask(issue_mask), .stall(stall), .flush(flush)
  );

  inflight_scoreboard u_scoreboard (
    .clk(clk), .rst(rst),
    .issue_even(issue_even), .issue_odd(issue_odd),
    .flush(flush),
    .even_stages(even_stages), .odd_stages(odd_stages)
  );

endmodule

`default_nettype wire

// File: testbench/tb_dual_issue_stage.sv
`default_nettype none
`include "spu_defines.svh"

module tb_dual_issue_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import spu_isa_pkg::*;
  import spu_pipe_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS = 6;
  localparam int TEST_BOUND = 60; // Cycles allowed for one test.

  typedef logic [`SPU_REG_W-1:0] reg_t;

  logic        clk;
  logic        rst;
  logic        pair_req;
  pair_t       pair;
  branch_rpt_t branch;
  logic        pair_ack;
  issue_t      issue_even;
  issue_t      issue_odd;
  logic        stall;
  logic        flush;

  int checks;
  int errors;
  int cyc;
  int flushes;
  int base;
  bit exp_flush;

  // Reference scoreboard with one record per observed register write.
  int m_dst [256];
  int m_lat [256];
  int m_at  [256];
  bit m_live[256];
  int m_n;

  dual_issue_stage uut (
    .clk(clk), .rst(rst),
    .pair_req(pair_req), .pair(pair), .branch(branch),
    .pair_ack(pair_ack), .issue_even(issue_even), .issue_odd(issue_odd),
    .stall(stall), .flush(flush)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * TEST_BOUND * CLK_PERIOD);
    $display("Watchdog expired before the tests completed.");
    $display("TESTS FAILED");
    $finish;
  end

  // ######################################
  // Reference rules.
  // ######################################

  function automatic int lat_of(opcode_e op);
    case (op)
      op_add, op_shift: return 2;
      op_shuffle:       return 4;
      op_load:          return 6;
      op_mpy, op_fp:    return 7;
      default:          return 1;
    endcase
  endfunction

  function automatic bit is_odd_pipe(opcode_e op);
    return op inside {op_shift, op_load, op_store, op_shuffle, op_branch};
  endfunction

  function automatic int rn(int i);
    return (base + i) % `SPU_NUM_REGS;
  endfunction

  // A negative register number leaves that source unused.
  function automatic instr_t mk(opcode_e op, int dst, int ra, int rb, int rc);
    instr_t ins;
    ins = '0;
    ins.opcode = op;
    ins.dst = reg_t'(dst);
    ins.writes_dst = (op != op_nop) && (op != op_store);
    ins.uses_ra = (ra >= 0);
    ins.uses_rb = (rb >= 0);
    ins.uses_rc = (rc >= 0);
    ins.ra = reg_t'(ra >= 0 ? ra : 0);
    ins.rb = reg_t'(rb >= 0 ? rb : 0);
    ins.rc = reg_t'(rc >= 0 ? rc : 0);
    return ins;
  endfunction

  function automatic pair_t pair_of(instr_t older, instr_t younger);
    pair_t p;
    p.slot0 = older;
    p.slot1 = younger;
    return p;
  endfunction

  function automatic bit reads(instr_t ins, int r);
    return (ins.uses_ra && int'(ins.ra) == r) || (ins.uses_rb && int'(ins.rb) == r) ||
           (ins.uses_rc && int'(ins.rc) == r);
  endfunction

  function automatic bit pair_splits(pair_t p);
    return (is_odd_pipe(p.slot0.opcode) == is_odd_pipe(p.slot1.opcode)) ||
           (p.slot0.writes_dst && p.slot1.writes_dst && p.slot0.dst == p.slot1.dst) ||
           (p.slot0.writes_dst && reads(p.slot1, int'(p.slot0.dst)));
  endfunction

  // A write blocks readers strictly between its issue cycle and issue plus latency.
  function automatic bit src_blocked(int r);
    for (int i = 0; i < m_n; i++) begin
      if (m_live[i] && m_dst[i] == r && cyc > m_at[i] && cyc < m_at[i] + m_lat[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic bit blocked(instr_t ins);
    return (ins.uses_ra && src_blocked(int'(ins.ra))) ||
           (ins.uses_rb && src_blocked(int'(ins.rb))) ||
           (ins.uses_rc && src_blocked(int'(ins.rc)));
  endfunction

  function automatic issue_t expect_issue(instr_t ins);
    issue_t e;
    e.valid = 1'b1;
    e.opcode = ins.opcode;
    e.dst = ins.dst;
    e.latency = `SPU_LAT_W'(lat_of(ins.opcode));
    return e;
  endfunction

  function automatic void record_issue(issue_t i);
    if (i.valid && i.opcode != op_nop && i.opcode != op_store && m_n < 256) begin
      m_dst[m_n] = int'(i.dst);
      m_lat[m_n] = lat_of(i.opcode);
      m_at[m_n] = cyc;
      m_live[m_n] = 1'b1;
      m_n++;
    end
  endfunction

  // Writes issued in the last few cycles are still younger than the resolve stage.
  function automatic void kill_young();
    for (int i = 0; i < m_n; i++) begin
      if (m_at[i] >= cyc - `SPU_RESOLVE_STAGE && m_at[i] < cyc) m_live[i] = 1'b0;
    end
  endfunction

  // ######################################
  // Checking and stimulus.
  // ######################################

  task automatic check_equal(string name, logic [31:0] actual, logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic tick();
    @(negedge clk);
    cyc++;
    exp_flush = branch.valid && branch.taken; // Sampled at the last rising edge.
    branch = '0;
    check_equal("flush", 32'(flush), 32'(exp_flush));
    if (flush) flushes++;
    if (exp_flush) kill_young();
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      tick();
      check_equal("issue_even", 32'(issue_even), 0);
      check_equal("issue_odd", 32'(issue_odd), 0);
      check_equal("stall", 32'(stall), 0);
      check_equal("pair_ack", 32'(pair_ack), 0);
    end
  endtask

  // Runs one four-phase handshake and checks every cycle against the model.
  task automatic run_pair(input pair_t p, input int branch_at, output int t0, output int t1,
                          output int req_at, output int stalls);
    bit     rem0;
    bit     rem1;
    bit     done;
    bit     g0;
    bit     g1;
    bit     exp_stall;
    bit     exp_ack;
    int     done_at;
    issue_t exp_even;
    issue_t exp_odd;
    rem0 = 1'b1;
    rem1 = 1'b1;
    done = 1'b0;
    done_at = 0;
    t0 = -1;
    t1 = -1;
    stalls = 0;
    pair = p;
    pair_req = 1'b1;
    req_at = cyc;
    while (1) begin
      tick();
      g0 = 1'b0;
      g1 = 1'b0;
      exp_stall = 1'b0;
      if (exp_flush && !done && cyc >= req_at + 1) begin
        rem0 = 1'b0; // The held pair is dropped.
        rem1 = 1'b0;
      end else if (!exp_flush && !done && cyc >= req_at + 2) begin
        if (rem0) begin
          if (blocked(p.slot0)) begin
            exp_stall = 1'b1;
          end else begin
            g0 = 1'b1;
            g1 = !pair_splits(p) && !blocked(p.slot1);
          end
        end else if (blocked(p.slot1)) begin
          exp_stall = 1'b1;
        end else begin
          g1 = 1'b1;
        end
      end
      exp_ack = done && cyc > done_at && pair_req;
      exp_even = '0;
      exp_odd = '0;
      if (g0 && is_odd_pipe(p.slot0.opcode)) exp_odd = expect_issue(p.slot0);
      if (g0 && !is_odd_pipe(p.slot0.opcode)) exp_even = expect_issue(p.slot0);
      if (g1 && is_odd_pipe(p.slot1.opcode)) exp_odd = expect_issue(p.slot1);
      if (g1 && !is_odd_pipe(p.slot1.opcode)) exp_even = expect_issue(p.slot1);
      check_equal("issue_even", 32'(issue_even), 32'(exp_even));
      check_equal("issue_odd", 32'(issue_odd), 32'(exp_odd));
      check_equal("stall", 32'(stall), 32'(exp_stall));
      check_equal("pair_ack", 32'(pair_ack), 32'(exp_ack));
      record_issue(issue_even);
      record_issue(issue_odd);
      if (stall) stalls++;
      if (g0) begin
        rem0 = 1'b0;
        t0 = cyc;
      end
      if (g1) begin
        rem1 = 1'b0;
        t1 = cyc;
      end
      if (!done && !rem0 && !rem1) begin
        done = 1'b1;
        done_at = cyc;
      end
      if (cyc == req_at + branch_at) branch = '{valid: 1'b1, taken: 1'b1};
      if (cyc - req_at > TEST_BOUND) begin
        errors++;
        $display("Pair handshake did not complete within %0d cycles.", TEST_BOUND);
        pair_req = 1'b0;
        break;
      end
      if (pair_req && pair_ack) pair_req = 1'b0;
      else if (!pair_req) break; // Ack seen low again.
    end
  endtask

  task automatic start_test();
    idle_cycles(`SPU_PIPE_DEPTH + 1); // Lets earlier writes drain.
    base = int'($urandom % `SPU_NUM_REGS);
  endtask

  // ######################################
  // Directed tests.
  // ######################################

  task automatic test_reset();
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_equal("pair_ack", 32'(pair_ack), 0);
    check_equal("stall", 32'(stall), 0);
    check_equal("flush", 32'(flush), 0);
    check_equal("issue_even.valid", 32'(issue_even.valid), 0);
    check_equal("issue_odd.valid", 32'(issue_odd.valid), 0);
    rst = 1'b0;
    cyc = 0;
  endtask

  task automatic test_independent();
    int t0, t1, req_at, stalls;
    start_test();
    run_pair(pair_of(mk(op_add, rn(0), rn(1), rn(2), -1), mk(op_shift, rn(3), rn(4), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("slot0 issue cycle", t0, req_at + 2);
    check_equal("slot1 issue cycle", t1, t0);
    check_equal("stall cycles", stalls, 0);
  endtask

  task automatic test_split();
    int t0, t1, req_at, stalls;
    start_test();
    run_pair(pair_of(mk(op_add, rn(0), rn(1), -1, -1), mk(op_logic_op, rn(2), rn(3), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("same pipe slot1 issue cycle", t1, t0 + 1);
    run_pair(pair_of(mk(op_add, rn(4), rn(1), -1, -1), mk(op_shift, rn(4), rn(5), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("same dst slot1 issue cycle", t1, t0 + 1);
    run_pair(pair_of(mk(op_add, rn(6), rn(1), -1, -1), mk(op_shift, rn(7), rn(6), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("pair raw slot1 issue cycle", t1, t0 + lat_of(op_add));
    check_equal("pair raw stall cycles", stalls, lat_of(op_add) - 1);
  endtask

  task automatic test_raw_stall();
    int ta0, ta1, t0, t1, req_at, stalls, ready_at;
    start_test();
    run_pair(pair_of(mk(op_load, rn(0), rn(1), -1, -1), mk(op_add, rn(2), rn(3), -1, -1)),
             -1, ta0, ta1, req_at, stalls);
    run_pair(pair_of(mk(op_fp, rn(4), rn(6), rn(7), rn(0)), mk(op_shift, rn(5), rn(8), -1, -1)),
             -1, t0, t1, req_at, stalls);
    ready_at = ta0 + lat_of(op_load);
    check_equal("reader issue cycle", t0, (req_at + 2 > ready_at) ? req_at + 2 : ready_at);
    check_equal("reader stall cycles", stalls, t0 - (req_at + 2));
    check_equal("reader slot1 issue cycle", t1, t0);
  endtask

  task automatic test_ready_no_block();
    int t0, t1, req_at, stalls;
    start_test();
    run_pair(pair_of(mk(op_logic_op, rn(0), rn(1), -1, -1), mk(op_shift, rn(2), rn(0), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("logic_op reader issue cycle", t1, t0 + 1);
    check_equal("logic_op reader stall cycles", stalls, 0);
    run_pair(pair_of(mk(op_store, rn(3), rn(4), rn(5), -1), mk(op_add, rn(6), rn(3), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("store reader issue cycle", t1, t0);
    check_equal("store reader stall cycles", stalls, 0);
    run_pair(pair_of(mk(op_nop, rn(7), -1, -1, -1), mk(op_shift, rn(8), rn(7), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("nop reader issue cycle", t1, t0);
    check_equal("nop reader stall cycles", stalls, 0);
  endtask

  task automatic test_branch_flush();
    int t0, t1, req_at, stalls, flushes_before;
    start_test();
    branch = '{valid: 1'b1, taken: 1'b0}; // A branch not taken.
    idle_cycles(2);
    flushes_before = flushes;
    // Slot1 waits on the mpy when the taken branch arrives.
    run_pair(pair_of(mk(op_mpy, rn(0), rn(1), rn(2), -1), mk(op_shift, rn(3), rn(0), -1, -1)),
             3, t0, t1, req_at, stalls);
    check_equal("flushed pair slot0 issue cycle", t0, req_at + 2);
    check_equal("flushed pair slot1 issue cycle", t1, -1);
    check_equal("flush cycles", flushes - flushes_before, 1);
    run_pair(pair_of(mk(op_shift, rn(4), rn(0), -1, -1), mk(op_add, rn(5), rn(6), -1, -1)),
             -1, t0, t1, req_at, stalls);
    check_equal("post flush reader issue cycle", t0, req_at + 2);
    check_equal("post flush reader stall cycles", stalls, 0);
  endtask

  initial begin
    rst = 1'b1;
    pair_req = 1'b0;
    pair = '0;
    branch = '0;
    checks = 0;
    errors = 0;
    cyc = 0;
    flushes = 0;
    m_n = 0;
    base = 0;
    void'($urandom(90418));
    test_reset();
    test_independent();
    test_split();
    test_raw_stall();
    test_ready_no_block();
    test_branch_flush();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/spu_isa_pkg.sv
hdl/spu_pipe_pkg.sv
hdl/pair_decoder.sv
hdl/inflight_scoreboard.sv
hdl/hazard_unit.sv
hdl/dual_issue_stage.sv
testbench/tb_dual_issue_stage.sv

// File: Makefile
# Verilator build and run for the dual-issue stage testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_dual_issue_stage
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass line appears in the simulator output.
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
